// ==== test/perf_monitor_tests.txt ====
# S <icache rwhp> <dcache rwhp> <pipe: 3 stall, 3 invalid, resolve taken pred> <clear>
# C <counter index> <expected count>; I is a random idle gap
# icache read, hit two cycles later
S 1000 0000 000000000 0
S 0000 0000 000000000 0
S 0011 0000 000000000 0
C 0 1
C 1 0
C 2 0
I
# dcache write, 6 cycles without resp, read in between ignored
S 0000 0100 000000000 0
S 0000 0000 000000000 0
S 0000 1000 000000000 0
S 0000 0000 000000000 0
S 0000 0000 000000000 0
S 0000 0000 000000000 0
S 0000 0000 000000000 0
S 0000 0001 000000000 0
C 3 1
C 4 1
C 5 3
I
# stall cycles and flush slots
S 0000 0000 100000000 0
S 0000 0000 011000000 0
S 0000 0000 000111000 0
S 0000 0000 000010000 0
C 6 2
C 7 4
# branches, the last has no resolve
S 0000 0000 000000111 0
S 0000 0000 000000110 0
S 0000 0000 000000101 0
S 0000 0000 000000011 0
C 8 3
C 9 2
I
# clear in the same cycle as events
S 0011 0011 111111111 1
C 0 0
C 1 0
C 2 0
C 3 0
C 4 0
C 5 0
C 6 0
C 7 0
C 8 0
C 9 0
S 0000 0000 100000110 0
S 1000 0000 000000000 0
S 0011 0000 000000000 0
C 0 1
C 1 0
C 6 1
C 8 1
C 9 1
# dcache resp without hit while pending
S 0000 1000 000000000 0
S 0000 0001 000000000 0
C 3 1
C 4 1
C 5 0

// ==== perf_monitor.f ====
rtl/perf_cfg_pkg.sv
rtl/perf_event_pkg.sv
rtl/cache_miss_fsm.sv
rtl/pipeline_waste_tally.sv
rtl/perf_counter_bank.sv
rtl/perf_monitor.sv
test/tb_clock_gen.sv
test/tb_perf_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the perf_monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_perf_monitor \
    -f perf_monitor.f -o Vtb_perf_monitor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_perf_monitor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== test/tb_perf_monitor.sv ====
module tb_perf_monitor;

    // one parsed line of the tests file
    typedef struct packed {
        logic [7:0]                 kind;
        perf_event_pkg::cache_evt_t ic;
        perf_event_pkg::cache_evt_t dc;
        perf_event_pkg::pipe_evt_t  pipe;
        logic                       clr;
        perf_cfg_pkg::ctr_idx_t     idx;
        perf_cfg_pkg::count_t       expected;
    } step_t;

    logic                       clk;
    logic                       rst_n;
    perf_event_pkg::cache_evt_t icache_evt;
    perf_event_pkg::cache_evt_t dcache_evt;
    perf_event_pkg::pipe_evt_t  pipe_evt;
    logic                       clear;
    perf_cfg_pkg::ctr_idx_t     rd_index;
    perf_cfg_pkg::count_t       rd_data;

    step_t steps[$];
    int    errors;
    int    checks;
    int    cycle_limit;
    int    cycle_count = 0;

    tb_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

    perf_monitor perf_monitor_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .icache_evt(icache_evt),
        .dcache_evt(dcache_evt),
        .pipe_evt  (pipe_evt),
        .clear     (clear),
        .rd_index  (rd_index),
        .rd_data   (rd_data)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t: %s read %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    // all strobes low so idle FSMs stay idle
    task automatic drive_idle();
        icache_evt <= '0;
        dcache_evt <= '0;
        pipe_evt   <= '0;
        clear      <= 1'b0;
    endtask

    task automatic load_tests();
        int         fd;
        int         code;
        int         line_no;
        int         idx;
        int         value;
        string      line;
        step_t      step;
        logic [3:0] ic_bits;
        logic [3:0] dc_bits;
        logic [8:0] pipe_bits;
        logic       clr_bit;
        fd = $fopen("test/perf_monitor_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file test/perf_monitor_tests.txt");
            errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            // blank lines and comments
            if (code == 0 || line.len() < 2 || line[0] == "#") continue;
            step = '0;
            step.kind = line[0];
            if (line[0] == "S" &&
                $sscanf(line, "S %b %b %b %b", ic_bits, dc_bits, pipe_bits, clr_bit) == 4) begin
                step.ic   = perf_event_pkg::cache_evt_t'(ic_bits);
                step.dc   = perf_event_pkg::cache_evt_t'(dc_bits);
                step.pipe = perf_event_pkg::pipe_evt_t'(pipe_bits);
                step.clr  = clr_bit;
                steps.push_back(step);
            end else if (line[0] == "C" && $sscanf(line, "C %d %d", idx, value) == 2 &&
                         idx >= 0 && idx < perf_cfg_pkg::NUM_CTRS) begin
                step.idx      = perf_cfg_pkg::ctr_idx_t'(idx[3:0]);
                step.expected = perf_cfg_pkg::count_t'(value);
                steps.push_back(step);
            end else if (line[0] == "I") begin
                steps.push_back(step);
            end else begin
                $display("malformed line %0d in the tests file: %s", line_no, line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // hang guard with its limit set once the tests are loaded
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int    fill;
        step_t step;
        errors      = 0;
        checks      = 0;
        cycle_limit = 0;
        rst_n       = 1'b0;
        icache_evt  = '0;
        dcache_evt  = '0;
        pipe_evt    = '0;
        clear       = 1'b0;
        rd_index    = perf_cfg_pkg::CTR_IC_ACCESS;
        void'($urandom(32'h64942e7b));
        load_tests();
        cycle_limit = 2 * steps.size() + 100;
        // 4 edges with reset low
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            step = steps[i];
            case (step.kind)
                "S": begin
                    @(posedge clk);
                    icache_evt <= step.ic;
                    dcache_evt <= step.dc;
                    pipe_evt   <= step.pipe;
                    clear      <= step.clr;
                end
                "C": begin
                    // previous cycle lands in the bank on this edge
                    @(posedge clk);
                    drive_idle();
                    rd_index <= step.idx;
                    @(negedge clk);
                    check_value(rd_data, step.expected,
                                $sformatf("counter %0d", step.idx));
                end
                "I": begin
                    // filler gap of 0 to 2 quiet cycles
                    fill = $urandom % 3;
                    repeat (fill) begin
                        @(posedge clk);
                        drive_idle();
                    end
                end
                default: begin
                end
            endcase
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // free running, first rising edge at half a period
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== rtl/perf_monitor.sv ====
module perf_monitor #(
    parameter int COUNT_WIDTH    = perf_cfg_pkg::DEF_COUNT_WIDTH,
    parameter int MISS_THRESHOLD = perf_cfg_pkg::DEF_MISS_THRESHOLD
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  perf_event_pkg::cache_evt_t icache_evt,
    input  perf_event_pkg::cache_evt_t dcache_evt,
    input  perf_event_pkg::pipe_evt_t  pipe_evt,
    input  logic                       clear,
    input  perf_cfg_pkg::ctr_idx_t     rd_index,
    output perf_cfg_pkg::count_t       rd_data
);

    perf_event_pkg::cache_stat_t ic_stat;
    perf_event_pkg::cache_stat_t dc_stat;
    perf_event_pkg::inc_vec_t    inc;
    perf_cfg_pkg::inc_t          stall_inc;
    perf_cfg_pkg::inc_t          flush_inc;
    perf_cfg_pkg::inc_t          br_inc;
    perf_cfg_pkg::inc_t          br_miss_inc;

    cache_miss_fsm #(
        .MISS_THRESHOLD(MISS_THRESHOLD)
    ) u_icache_fsm (
        .clk  (clk),
        .rst_n(rst_n),
        .evt  (icache_evt),
        .stat (ic_stat)
    );

    cache_miss_fsm #(
        .MISS_THRESHOLD(MISS_THRESHOLD)
    ) u_dcache_fsm (
        .clk  (clk),
        .rst_n(rst_n),
        .evt  (dcache_evt),
        .stat (dc_stat)
    );

    pipeline_waste_tally u_tally (
        .clk        (clk),
        .rst_n      (rst_n),
        .pipe_evt   (pipe_evt),
        .stall_inc  (stall_inc),
        .flush_inc  (flush_inc),
        .br_inc     (br_inc),
        .br_miss_inc(br_miss_inc)
    );

    // cache strobes widen to 0 or 1 per lane
    assign inc[perf_cfg_pkg::CTR_IC_ACCESS]   = perf_cfg_pkg::inc_t'(ic_stat.access);
    assign inc[perf_cfg_pkg::CTR_IC_MISS]     = perf_cfg_pkg::inc_t'(ic_stat.miss);
    assign inc[perf_cfg_pkg::CTR_IC_MISS_CYC] = perf_cfg_pkg::inc_t'(ic_stat.miss_cycle);
    assign inc[perf_cfg_pkg::CTR_DC_ACCESS]   = perf_cfg_pkg::inc_t'(dc_stat.access);
    assign inc[perf_cfg_pkg::CTR_DC_MISS]     = perf_cfg_pkg::inc_t'(dc_stat.miss);
    assign inc[perf_cfg_pkg::CTR_DC_MISS_CYC] = perf_cfg_pkg::inc_t'(dc_stat.miss_cycle);
    // pipeline lanes come out of the tally already sized
    assign inc[perf_cfg_pkg::CTR_STALL_CYC]   = stall_inc;
    assign inc[perf_cfg_pkg::CTR_FLUSH_SLOT]  = flush_inc;
    assign inc[perf_cfg_pkg::CTR_BR_RESOLVE]  = br_inc;
    assign inc[perf_cfg_pkg::CTR_BR_MISS]     = br_miss_inc;

    perf_counter_bank #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .inc     (inc),
        .rd_index(rd_index),
        .rd_data (rd_data)
    );

endmodule

// ==== rtl/perf_counter_bank.sv ====
module perf_counter_bank #(
    parameter int COUNT_WIDTH = perf_cfg_pkg::DEF_COUNT_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  perf_event_pkg::inc_vec_t inc,
    input  perf_cfg_pkg::ctr_idx_t   rd_index,
    output perf_cfg_pkg::count_t     rd_data
);

    // counters have to fit on the read bus
    if (COUNT_WIDTH < 2 || COUNT_WIDTH > perf_cfg_pkg::COUNT_WIDTH) begin : g_bad_width
        $error("perf_counter_bank: COUNT_WIDTH out of range for count_t");
    end

    localparam int N = perf_cfg_pkg::NUM_CTRS;

    // counter value and its sum with one spare carry bit
    typedef logic [COUNT_WIDTH-1:0] ctr_val_t;
    typedef logic [COUNT_WIDTH:0]   ctr_sum_t;

    ctr_val_t ctr_q [N];
    ctr_val_t ctr_d [N];

    for (genvar i = 0; i < N; i++) begin : g_ctr
        ctr_sum_t sum;

        assign sum = ctr_sum_t'(ctr_q[i]) + ctr_sum_t'(inc[i]);

        // stick at all ones once the carry shows up
        assign ctr_d[i] = sum[COUNT_WIDTH] ? '1 : sum[COUNT_WIDTH-1:0];

        // clear wins over the increments of the same cycle
        a_clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
            clear |=> (ctr_q[i] == '0));

        // only clear or reset may move a counter down
        a_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
            !clear |=> (ctr_q[i] >= $past(ctr_q[i])));
    end

    // reset and clear both zero the whole bank
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            ctr_q <= '{default: '0};
        end else begin
            ctr_q <= ctr_d;
        end
    end

    // read mux straight off the registers
    // unused index codes read as zero
    always_comb begin
        rd_data = '0;
        if (int'(rd_index) < N) begin
            rd_data = perf_cfg_pkg::count_t'(ctr_q[rd_index]);
        end
    end

endmodule

// ==== rtl/pipeline_waste_tally.sv ====
module pipeline_waste_tally (
    // clock and reset only sample the checker below
    input  logic                      clk,
    input  logic                      rst_n,
    input  perf_event_pkg::pipe_evt_t pipe_evt,
    output perf_cfg_pkg::inc_t        stall_inc,
    output perf_cfg_pkg::inc_t        flush_inc,
    output perf_cfg_pkg::inc_t        br_inc,
    output perf_cfg_pkg::inc_t        br_miss_inc
);

    logic any_stall;
    logic br_mispredict;

    // a cycle counts once however many stages stall
    assign any_stall = pipe_evt.stall_if_de
                     | pipe_evt.stall_de_exe
                     | pipe_evt.stall_exe_mem;

    // outcome only meaningful on a resolve cycle
    assign br_mispredict = pipe_evt.branch_resolve
                         & (pipe_evt.branch_taken ^ pipe_evt.branch_prediction);

    assign stall_inc = perf_cfg_pkg::inc_t'(any_stall);

    // one slot per empty stage, up to 3 per cycle
    // mispredict cost lands here as flushed slots
    assign flush_inc = perf_cfg_pkg::inc_t'(pipe_evt.fetch_invalid)
                     + perf_cfg_pkg::inc_t'(pipe_evt.decode_invalid)
                     + perf_cfg_pkg::inc_t'(pipe_evt.exe_invalid);

    assign br_inc      = perf_cfg_pkg::inc_t'(pipe_evt.branch_resolve);
    assign br_miss_inc = perf_cfg_pkg::inc_t'(br_mispredict);

    // BR_MISS can never run ahead of BR_RESOLVE in the bank
    a_br_miss_implies_resolve: assert property (@(posedge clk) disable iff (!rst_n)
        (br_miss_inc != '0) |-> (br_inc != '0));

endmodule

// ==== rtl/cache_miss_fsm.sv ====
module cache_miss_fsm #(
    parameter int MISS_THRESHOLD = perf_cfg_pkg::DEF_MISS_THRESHOLD
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  perf_event_pkg::cache_evt_t evt,
    output perf_event_pkg::cache_stat_t stat
);

    // threshold has to fit the wait counter and be reachable
    if (MISS_THRESHOLD < 1 || MISS_THRESHOLD > 15) begin : g_bad_threshold
        $error("cache_miss_fsm: MISS_THRESHOLD must be in 1..15");
    end

    typedef enum logic [1:0] {
        idle    = 2'd0,
        pending = 2'd1,
        miss    = 2'd2
    } state_t;

    state_t              state_q;
    state_t              state_d;
    perf_cfg_pkg::wait_t wait_q;
    perf_cfg_pkg::wait_t wait_d;

    // next state and strobes, purely from state and inputs
    always_comb begin
        state_d = state_q;
        wait_d  = wait_q;
        stat    = '0;
        case (state_q)
            idle: begin
                // new access, first pending cycle is cycle 1
                if (evt.read || evt.write) begin
                    stat.access = 1'b1;
                    state_d     = pending;
                    wait_d      = perf_cfg_pkg::wait_t'(1);
                end
            end
            pending: begin
                if (evt.resp) begin
                    // resp without hit is a miss with no waste cycles
                    stat.miss = !evt.hit;
                    state_d   = idle;
                    wait_d    = '0;
                end else if (wait_q == perf_cfg_pkg::wait_t'(MISS_THRESHOLD)) begin
                    // waited too long, declare the miss now
                    stat.miss = 1'b1;
                    state_d   = miss;
                    wait_d    = '0;
                end else begin
                    wait_d = wait_q + perf_cfg_pkg::wait_t'(1);
                end
            end
            miss: begin
                // each cycle still waiting is a wasted one
                if (evt.resp) begin
                    state_d = idle;
                end else begin
                    stat.miss_cycle = 1'b1;
                end
            end
            default: begin
                state_d = idle;
                wait_d  = '0;
            end
        endcase
    end

    // requests outside idle fall through the case above untouched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
            wait_q  <= '0;
        end else begin
            state_q <= state_d;
            wait_q  <= wait_d;
        end
    end

    // encoding 3 is never entered
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {idle, pending, miss});

    // the miss cycle itself is not counted as waste
    a_miss_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(stat.miss && stat.miss_cycle));

    // pending leaves at the threshold at the latest
    a_wait_bound: assert property (@(posedge clk) disable iff (!rst_n)
        wait_q <= perf_cfg_pkg::wait_t'(MISS_THRESHOLD));

endmodule

// ==== rtl/perf_event_pkg.sv ====
package perf_event_pkg;

    // per-cycle strobes from one cache
    // icache has no write path, its write bit stays 0
    typedef struct packed {
        logic read;
        logic write;
        logic hit;
        logic resp;
    } cache_evt_t;

    // per-cycle strobes from the pipeline
    typedef struct packed {
        // hazard stalls between stages
        logic stall_if_de;
        logic stall_de_exe;
        logic stall_exe_mem;
        // bubbles left by a flush
        logic fetch_invalid;
        logic decode_invalid;
        logic exe_invalid;
        // branch outcome vs predictor
        logic branch_resolve;
        logic branch_taken;
        logic branch_prediction;
    } pipe_evt_t;

    // classification strobes for the current cycle
    typedef struct packed {
        logic access;
        logic miss;
        logic miss_cycle;
    } cache_stat_t;

    // one increment lane per counter, indexed by ctr_idx_t
    typedef perf_cfg_pkg::inc_t [perf_cfg_pkg::NUM_CTRS-1:0] inc_vec_t;

endpackage

// ==== rtl/perf_cfg_pkg.sv ====
package perf_cfg_pkg;

    // defaults handed down by the top level
    localparam int DEF_COUNT_WIDTH    = 16;
    localparam int DEF_MISS_THRESHOLD = 3;

    // width of the counter read bus
    localparam int COUNT_WIDTH = DEF_COUNT_WIDTH;

    // number of counters in the bank
    localparam int NUM_CTRS = 10;

    // one counter value as seen on the read port
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // per-cycle increment amount, 0 to 3
    typedef logic [1:0] inc_t;

    // cycles an access has been pending
    typedef logic [3:0] wait_t;

    // counter index, also the lane number in the increment vector
    typedef enum logic [3:0] {
        CTR_IC_ACCESS   = 4'd0,
        CTR_IC_MISS     = 4'd1,
        CTR_IC_MISS_CYC = 4'd2,
        CTR_DC_ACCESS   = 4'd3,
        CTR_DC_MISS     = 4'd4,
        CTR_DC_MISS_CYC = 4'd5,
        CTR_STALL_CYC   = 4'd6,
        CTR_FLUSH_SLOT  = 4'd7,
        CTR_BR_RESOLVE  = 4'd8,
        CTR_BR_MISS     = 4'd9
    } ctr_idx_t;

endpackage
